/* hw/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define DATA_W 8
`define ADDR_W 8
`define MEM_DEPTH 256

// byte mirrored on the test port.
`define RESULT_ADDR 128

// opcode bits 7:6.
`define GRP_ALU 2'b00
`define GRP_STORE 2'b01
`define GRP_JUMP 2'b10
`define GRP_HALT 2'b11

`endif

/* hw/cpuPkg.sv */
package cpuPkg;

	typedef enum logic [2:0] {
		opLoad,
		opAdd,
		opSub,
		opAnd,
		opOr,
		opXor,
		opShl,
		opShr
	} aluOpT;

	typedef enum logic [1:0] {
		condAlways,
		condZero,
		condNonZero,
		condCarry
	} jumpCondT;

	// opcode byte read as an ALU op or as a jump.
	typedef union packed {
		struct packed {
			logic [1:0] group;
			aluOpT      op;
			logic       imm; // operand byte is the value itself.
			logic [1:0] spare;
		} alu;
		struct packed {
			logic [1:0] group;
			jumpCondT   cond;
			logic [3:0] spare;
		} jump;
	} instrWordT;

endpackage

/* hw/upMemory.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module upMemory (
	input  logic               clk,
	input  logic               nRst,
	input  logic [`DATA_W-1:0] in,
	input  logic [`ADDR_W-1:0] address,
	input  logic               we,
	output logic [`DATA_W-1:0] out,
	output logic [`DATA_W-1:0] test
);

	logic [`DATA_W-1:0] mem [`MEM_DEPTH];

	// sums 5+4+3+2+1 using byte 129 as counter and 130 as running total.
	function automatic logic [`DATA_W-1:0] bootByte(input int idx);
		case (idx)
			0:  return 8'h04; // ldi 5.
			1:  return 8'h05;
			2:  return 8'h40; // st 129.
			3:  return 8'h81;
			4:  return 8'h04; // ldi 0.
			5:  return 8'h00;
			6:  return 8'h40; // st 130.
			7:  return 8'h82;
			8:  return 8'h00; // ld 130 at the loop head.
			9:  return 8'h82;
			10: return 8'h08; // add 129.
			11: return 8'h81;
			12: return 8'h40; // st 130.
			13: return 8'h82;
			14: return 8'h00; // ld 129.
			15: return 8'h81;
			16: return 8'h14; // subi 1.
			17: return 8'h01;
			18: return 8'h40; // st 129.
			19: return 8'h81;
			20: return 8'hA0; // jnz loop.
			21: return 8'h08;
			22: return 8'h00; // ld 130.
			23: return 8'h82;
			24: return 8'h40; // st 128.
			25: return 8'h80;
			26: return 8'hC0; // halt.
			default: return '0;
		endcase
	endfunction

	assign out = mem[address];
	assign test = mem[`RESULT_ADDR];

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			for (int i = 0; i < `MEM_DEPTH; i++) begin
				mem[i] <= bootByte(i);
			end
		end else if (we) begin
			mem[address] <= in;
		end
	end

endmodule

/* hw/accAlu.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module accAlu import cpuPkg::*; (
	input  logic               clk,
	input  logic               nRst,
	input  aluOpT              aluOp,
	input  logic [`DATA_W-1:0] operand,
	input  logic [`DATA_W-1:0] acc,
	input  logic               aluStrobe,
	output logic [`DATA_W-1:0] aluResult,
	output logic               zeroFlag,
	output logic               carryFlag
);

	logic [`DATA_W:0] sum;
	logic [`DATA_W:0] diff;
	logic             carryNext;

	assign sum = {1'b0, acc} + {1'b0, operand};
	assign diff = {1'b0, acc} - {1'b0, operand}; // top bit is the borrow.

	always_comb begin
		aluResult = operand;
		carryNext = 1'b0;
		case (aluOp)
			opLoad: aluResult = operand;
			opAdd: {carryNext, aluResult} = sum;
			opSub: {carryNext, aluResult} = diff;
			opAnd: aluResult = acc & operand;
			opOr: aluResult = acc | operand;
			opXor: aluResult = acc ^ operand;
			opShl: {carryNext, aluResult} = {acc, 1'b0};
			opShr: {aluResult, carryNext} = {1'b0, acc};
			default: aluResult = operand;
		endcase
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			zeroFlag <= 1'b0;
			carryFlag <= 1'b0;
		end else if (aluStrobe) begin
			zeroFlag <= (aluResult == '0);
			carryFlag <= carryNext;
		end
	end

endmodule

/* hw/branchUnit.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module branchUnit import cpuPkg::*; (
	input  logic [`ADDR_W-1:0] pc,
	input  logic [`DATA_W-1:0] operand,
	input  jumpCondT           jumpCond,
	input  logic               isJump,
	input  logic               zeroFlag,
	input  logic               carryFlag,
	output logic [`ADDR_W-1:0] nextPc
);

	localparam logic [`ADDR_W-1:0] instrLen = 2;

	logic condMet;

	always_comb begin
		case (jumpCond)
			condAlways: condMet = 1'b1;
			condZero: condMet = zeroFlag;
			condNonZero: condMet = !zeroFlag;
			condCarry: condMet = carryFlag;
			default: condMet = 1'b0;
		endcase
	end

	// everything that is not a taken jump steps over both bytes.
	assign nextPc = (isJump && condMet) ? operand : pc + instrLen;

endmodule

/* hw/cpuSequencer.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpuSequencer import cpuPkg::*; (
	input  logic               clk,
	input  logic               nRst,
	input  logic               run,
	input  logic [`ADDR_W-1:0] hostAddress,
	input  logic [`DATA_W-1:0] hostData,
	input  logic               hostWe,
	input  logic [`DATA_W-1:0] memRdData,
	input  logic [`DATA_W-1:0] aluResult,
	input  logic [`ADDR_W-1:0] nextPc,
	output logic [`ADDR_W-1:0] memAddress,
	output logic [`DATA_W-1:0] memWrData,
	output logic               memWe,
	output aluOpT              aluOp,
	output logic [`DATA_W-1:0] operand,
	output logic [`DATA_W-1:0] acc,
	output logic               aluStrobe,
	output logic [`ADDR_W-1:0] pc,
	output jumpCondT           jumpCond,
	output logic               isJump,
	output logic               halted
);

	localparam logic [1:0] stIdle = 2'd0;
	localparam logic [1:0] stFetchOp = 2'd1;
	localparam logic [1:0] stFetchArg = 2'd2;
	localparam logic [1:0] stExec = 2'd3;
	localparam logic [`ADDR_W-1:0] argOffset = 1;

	logic [1:0]         state;
	instrWordT          instr;
	logic [`DATA_W-1:0] argByte;
	logic               isAlu;
	logic               isStore;

	assign isAlu = (instr.alu.group == `GRP_ALU);
	assign isStore = (instr.alu.group == `GRP_STORE);
	assign isJump = (instr.jump.group == `GRP_JUMP);
	assign aluOp = instr.alu.op;
	assign jumpCond = instr.jump.cond;
	assign aluStrobe = run && (state == stExec) && isAlu;

	// memory mode reads the addressed byte in the execute cycle itself.
	assign operand = (isAlu && !instr.alu.imm) ? memRdData : argByte;

	always_comb begin
		memWrData = acc;
		memWe = 1'b0;
		case (state)
			stFetchOp: memAddress = pc;
			stFetchArg: memAddress = pc + argOffset;
			stExec: begin
				memAddress = argByte;
				memWe = isStore;
			end
			default: memAddress = pc;
		endcase
		if (!run) begin // host owns the bus.
			memAddress = hostAddress;
			memWrData = hostData;
			memWe = hostWe;
		end
	end

	always_ff @(posedge clk or negedge nRst) begin
		if (!nRst) begin
			state <= stIdle;
			pc <= '0;
			acc <= '0;
			halted <= 1'b0;
		end else if (!run) begin
			state <= stIdle;
			pc <= '0;
			acc <= '0;
			halted <= 1'b0;
		end else begin
			case (state)
				stIdle: if (!halted) state <= stFetchOp;
				stFetchOp: state <= stFetchArg;
				stFetchArg: begin
					if (instr.alu.group == `GRP_HALT) begin
						halted <= 1'b1;
						state <= stIdle;
					end else begin
						state <= stExec;
					end
				end
				stExec: begin
					pc <= nextPc;
					if (isAlu) acc <= aluResult;
					state <= stFetchOp;
				end
				default: state <= stIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (run && state == stFetchOp) instr <= memRdData;
		if (run && state == stFetchArg) argByte <= memRdData;
	end

endmodule

/* hw/upCore.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module upCore import cpuPkg::*; (
	input  logic               clk,
	input  logic               nRst,
	input  logic               run,
	input  logic [`ADDR_W-1:0] hostAddress,
	input  logic [`DATA_W-1:0] hostData,
	input  logic               hostWe,
	output logic               halted,
	output logic [`DATA_W-1:0] test
);

	logic [`ADDR_W-1:0] memAddress;
	logic [`DATA_W-1:0] memWrData;
	logic [`DATA_W-1:0] memRdData;
	logic               memWe;
	aluOpT              aluOp;
	logic [`DATA_W-1:0] operand;
	logic [`DATA_W-1:0] acc;
	logic               aluStrobe;
	logic [`DATA_W-1:0] aluResult;
	logic               zeroFlag;
	logic               carryFlag;
	logic [`ADDR_W-1:0] pc;
	logic [`ADDR_W-1:0] nextPc;
	jumpCondT           jumpCond;
	logic               isJump;

	upMemory upMemory_i (
		.clk(clk),
		.nRst(nRst),
		.in(memWrData),
		.address(memAddress),
		.we(memWe),
		.out(memRdData),
		.test(test)
	);

	cpuSequencer cpuSequencer_i (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.hostAddress(hostAddress),
		.hostData(hostData),
		.hostWe(hostWe),
		.memRdData(memRdData),
		.aluResult(aluResult),
		.nextPc(nextPc),
		.memAddress(memAddress),
		.memWrData(memWrData),
		.memWe(memWe),
		.aluOp(aluOp),
		.operand(operand),
		.acc(acc),
		.aluStrobe(aluStrobe),
		.pc(pc),
		.jumpCond(jumpCond),
		.isJump(isJump),
		.halted(halted)
	);

	accAlu accAlu_i (
		.clk(clk),
		.nRst(nRst),
		.aluOp(aluOp),
		.operand(operand),
		.acc(acc),
		.aluStrobe(aluStrobe),
		.aluResult(aluResult),
		.zeroFlag(zeroFlag),
		.carryFlag(carryFlag)
	);

	branchUnit branchUnit_i (
		.pc(pc),
		.operand(operand),
		.jumpCond(jumpCond),
		.isJump(isJump),
		.zeroFlag(zeroFlag),
		.carryFlag(carryFlag),
		.nextPc(nextPc)
	);

endmodule

/* sim/upCoreChecker.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module upCoreChecker (
	input  logic               clk,
	input  logic               run,
	input  logic               halted,
	input  logic [`DATA_W-1:0] test,
	input  logic [`DATA_W-1:0] expResult,
	input  logic [15:0]        expCycles,
	input  logic [7:0]         entryIdx,
	output logic [31:0]        errCount,
	output logic [31:0]        checkCount,
	output logic [31:0]        haltCount
);

	int          errors = 0;
	int          checks = 0;
	int          halts = 0;
	logic [31:0] runCycles = '0; // negedges seen with run high and halted low.
	logic        haltSeen = 1'b0;
	logic        overrun = 1'b0;

	assign errCount = errors;
	assign checkCount = checks;
	assign haltCount = halts;

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s entry %0d: got 0x%0h, expected 0x%0h",
				name, entryIdx, got, want);
		end
	endtask

	always @(negedge clk) begin
		if (!run) begin
			runCycles = '0;
			haltSeen = 1'b0;
			overrun = 1'b0;
		end else if (!haltSeen) begin
			if (runCycles == 0) begin
				compareValue("test", 32'(test), 32'h000000A5); // host write landed.
			end
			if (halted) begin
				haltSeen = 1'b1;
				halts++;
				compareValue("halted cycles", runCycles, 32'(expCycles));
				compareValue("test", 32'(test), 32'(expResult));
			end else begin
				runCycles++;
				if (runCycles > 32'(expCycles) && !overrun) begin
					overrun = 1'b1;
					errors++;
					$display("entry %0d: halted still low %0d cycles after run rose",
						entryIdx, runCycles);
				end
			end
		end
	end

endmodule

/* sim/upCoreTb.sv */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module upCoreTb import cpuPkg::*; ();

	localparam int numEntries = 15;
	localparam int maxBytes = 16;

	logic               clk = 1'b0;
	logic               nRst;
	logic               run;
	logic [`ADDR_W-1:0] hostAddress;
	logic [`DATA_W-1:0] hostData;
	logic               hostWe;
	logic               halted;
	logic [`DATA_W-1:0] test;

	logic [`DATA_W-1:0] progBytes [numEntries][maxBytes];
	int                 progLen [numEntries];
	logic [`DATA_W-1:0] resultTable [numEntries];
	int                 instrTable [numEntries]; // instructions executed before halt.

	logic [`DATA_W-1:0] expResult;
	logic [15:0]        expCycles;
	logic [7:0]         entryIdx;
	logic [31:0]        errCount;
	logic [31:0]        checkCount;
	logic [31:0]        haltCount;
	int                 buildIdx;
	int                 cycles = 0;
	int                 cycleLimit;
	integer             seed;

	always #4 clk = ~clk;

	upCore upCore_i (
		.clk(clk),
		.nRst(nRst),
		.run(run),
		.hostAddress(hostAddress),
		.hostData(hostData),
		.hostWe(hostWe),
		.halted(halted),
		.test(test)
	);

	upCoreChecker upCoreChecker (
		.clk(clk),
		.run(run),
		.halted(halted),
		.test(test),
		.expResult(expResult),
		.expCycles(expCycles),
		.entryIdx(entryIdx),
		.errCount(errCount),
		.checkCount(checkCount),
		.haltCount(haltCount)
	);

	function automatic logic [7:0] aluInstr(input aluOpT op, input logic imm);
		instrWordT w;
		w.alu.group = `GRP_ALU;
		w.alu.op = op;
		w.alu.imm = imm;
		w.alu.spare = 2'b00;
		return w;
	endfunction

	function automatic logic [7:0] jumpInstr(input jumpCondT cond);
		instrWordT w;
		w.jump.group = `GRP_JUMP;
		w.jump.cond = cond;
		w.jump.spare = 4'h0;
		return w;
	endfunction

	function automatic logic [7:0] groupInstr(input logic [1:0] grp);
		return {grp, 6'b000000};
	endfunction

	task automatic emitInstr(input logic [7:0] code, input logic [7:0] arg);
		progBytes[buildIdx][progLen[buildIdx]] = code;
		progBytes[buildIdx][progLen[buildIdx] + 1] = arg;
		progLen[buildIdx] += 2;
	endtask

	task automatic emitStoreHalt();
		emitInstr(groupInstr(`GRP_STORE), 8'(`RESULT_ADDR));
		emitInstr(groupInstr(`GRP_HALT), 8'h00);
	endtask

	task automatic closeEntry(input logic [7:0] result, input int instrs);
		resultTable[buildIdx] = result;
		instrTable[buildIdx] = instrs;
		buildIdx++;
	endtask

	task automatic buildTable();
		logic [31:0] r;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  res;
		aluOpT       op;
		for (int e = 0; e < numEntries; e++) begin
			progLen[e] = 0;
		end
		buildIdx = 0;
		closeEntry(8'h0F, 41); // built-in program runs 4 setup, 5 passes of 7 and 2 closing.
		for (int k = 0; k < 8; k++) begin
			r = $random(seed);
			a = r[7:0];
			b = r[15:8];
			op = aluOpT'(k);
			case (op)
				opLoad: res = b;
				opAdd: res = a + b;
				opSub: res = a - b;
				opAnd: res = a & b;
				opOr: res = a | b;
				opXor: res = a ^ b;
				opShl: res = {a[6:0], 1'b0}; // operand byte ignored.
				default: res = {1'b0, a[7:1]};
			endcase
			emitInstr(aluInstr(opLoad, 1'b1), a);
			emitInstr(aluInstr(op, 1'b1), b);
			emitStoreHalt();
			closeEntry(res, 3);
		end
		r = $random(seed);
		a = r[7:0];
		b = r[15:8];
		emitInstr(aluInstr(opLoad, 1'b1), a);
		emitInstr(groupInstr(`GRP_STORE), 8'h8C);
		emitInstr(aluInstr(opLoad, 1'b1), b);
		emitInstr(groupInstr(`GRP_STORE), 8'h8D);
		emitInstr(aluInstr(opLoad, 1'b0), 8'h8C);
		emitInstr(aluInstr(opAdd, 1'b0), 8'h8D);
		emitStoreHalt();
		closeEntry(a + b, 7);
		r = $random(seed);
		a = r[7:0];
		b = r[15:8];
		emitInstr(aluInstr(opLoad, 1'b1), a);
		emitInstr(groupInstr(`GRP_STORE), 8'h8E);
		emitInstr(aluInstr(opLoad, 1'b1), b);
		emitInstr(aluInstr(opSub, 1'b0), 8'h8E);
		emitStoreHalt();
		closeEntry(b - a, 5);
		// jz skipped on a nonzero value and jnz taken over a load.
		emitInstr(aluInstr(opLoad, 1'b1), 8'h21);
		emitInstr(jumpInstr(condZero), 8'h0C);
		emitInstr(jumpInstr(condNonZero), 8'h08);
		emitInstr(aluInstr(opLoad, 1'b1), 8'h77);
		emitStoreHalt();
		emitInstr(groupInstr(`GRP_HALT), 8'h00);
		closeEntry(8'h21, 4);
		emitInstr(aluInstr(opLoad, 1'b1), 8'h05);
		emitInstr(aluInstr(opSub, 1'b1), 8'h05); // zero flag set.
		emitInstr(jumpInstr(condNonZero), 8'h0C);
		emitInstr(jumpInstr(condZero), 8'h0A);
		emitInstr(groupInstr(`GRP_HALT), 8'h00);
		emitStoreHalt();
		closeEntry(8'h00, 5);
		emitInstr(aluInstr(opLoad, 1'b1), 8'hF0);
		emitInstr(aluInstr(opAdd, 1'b1), 8'h20); // carries out.
		emitInstr(jumpInstr(condCarry), 8'h08);
		emitInstr(groupInstr(`GRP_HALT), 8'h00);
		emitStoreHalt();
		closeEntry(8'h10, 4);
		// countdown from 3 behind an unconditional jump.
		emitInstr(aluInstr(opLoad, 1'b1), 8'h03);
		emitInstr(jumpInstr(condAlways), 8'h06);
		emitInstr(groupInstr(`GRP_HALT), 8'h00);
		emitInstr(aluInstr(opSub, 1'b1), 8'h01);
		emitInstr(jumpInstr(condNonZero), 8'h06);
		emitInstr(aluInstr(opOr, 1'b1), 8'h5A);
		emitStoreHalt();
		closeEntry(8'h5A, 10);
	endtask

	function automatic int computeLimit();
		int total;
		total = 5;
		for (int e = 0; e < numEntries; e++) begin
			total += progLen[e] + 4 + 3 * instrTable[e] + 3 + 10;
		end
		return total;
	endfunction

	task automatic hostWrite(input logic [7:0] addr, input logic [7:0] data);
		@(posedge clk);
		hostAddress <= addr;
		hostData <= data;
		hostWe <= 1'b1;
	endtask

	task automatic runEntry(input int e);
		for (int i = 0; i < progLen[e]; i++) begin
			hostWrite(8'(i), progBytes[e][i]);
		end
		hostWrite(8'(`RESULT_ADDR), 8'hA5);
		expResult <= resultTable[e];
		expCycles <= 16'(3 * instrTable[e] + 3);
		entryIdx <= 8'(e);
		@(posedge clk);
		hostWe <= 1'b0;
		@(posedge clk);
		run <= 1'b1;
		hostWe <= 1'b1; // ignored while the core owns the bus.
		hostAddress <= 8'(`RESULT_ADDR);
		hostData <= 8'hEE;
		do @(negedge clk); while (!halted);
		@(posedge clk);
		run <= 1'b0;
		hostWe <= 1'b0;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout after %0d cycles, halted never rose for entry %0d",
				cycles, entryIdx);
			$display("Testbench failed");
			$finish;
		end
	end

	initial begin
		nRst = 1'b0;
		run = 1'b0;
		hostWe = 1'b0;
		hostAddress = '0;
		hostData = '0;
		expResult = '0;
		expCycles = '0;
		entryIdx = '0;
		seed = 32'h5f13d644;
		buildTable();
		cycleLimit = computeLimit();
		repeat (5) @(posedge clk);
		nRst <= 1'b1;
		for (int e = 0; e < numEntries; e++) begin
			runEntry(e);
		end
		repeat (4) @(posedge clk);
		$display("errors %0d, checks %0d, halts %0d of %0d", errCount, checkCount, haltCount,
			numEntries);
		if (errCount == 0 && haltCount == numEntries) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* sources.f */
+incdir+hw
hw/cpuPkg.sv
hw/upMemory.sv
hw/accAlu.sv
hw/branchUnit.sv
hw/cpuSequencer.sv
hw/upCore.sv
sim/upCoreChecker.sv
sim/upCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module upCoreTb -f sources.f -o upCoreSim > build.log 2>&1 \
	&& ./obj_dir/upCoreSim > sim.log 2>&1 \
	|| { cat build.log; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && exit 1
exit 0
